// File: sim.f
+incdir+design
+incdir+dv
design/sramHeadPkg.sv
design/sramArrayIf.sv
design/wordLineDecoder.sv
design/writeLaneSteering.sv
design/sramBitArray.sv
design/readByteMux.sv
design/sramHead.sv
dv/sramHeadTb.sv

// File: dv/sramHeadTasks.svh
`ifndef SRAMHEADTASKS_SVH
`define SRAMHEADTASKS_SVH

//##################################################
// Bookkeeping
//##################################################

task automatic compareByte(input byteT exp, input byteT act, input wordAddrT w,
	input laneSelT l);
	testChecks++;
	assert (act === exp) else begin
		$display("ERROR %s: word %0d lane %0d expected %h actual %h",
			curTest, w, l, exp, act);
		testErrors++;
	end
endtask

task automatic startTest(input string name);
	curTest = name;
	testChecks = 0;
	testErrors = 0;
endtask

//##################################################
// Pin drivers
//##################################################

// One access on the pins for one rising edge
task automatic accessCycle(input logic we, input logic re, input logic wle, input logic pc,
	input wordAddrT w, input laneSelT l, input byteT d);
	bit valid;
	valid = accessAllowed(we, re, wle, pc);
	@(negedge clk);
	writeEnable = we;
	readEnable = re;
	wordLineEnable = wle;
	preCharge = pc;
	wordSelect = w;
	byteSelect = l;
	dataIn = d;
	if (valid && we) begin
		shadow[w][l * `BYTE_W +: `BYTE_W] = d;
	end
	if (re) begin
		if (valid) begin
			predictedOut = expectedByte(w, l);
		end
		expQ.push_back(predictedOut);	// A gated read must leave dataOut alone
		dueQ.push_back(cycleCount + 1 + READ_LATENCY);
		wordQ.push_back(w);
		laneQ.push_back(l);
	end
endtask

task automatic writeByte(input wordAddrT w, input laneSelT l, input byteT d);
	accessCycle(1'b1, 1'b0, 1'b1, 1'b0, w, l, d);
endtask

task automatic readByte(input wordAddrT w, input laneSelT l);
	accessCycle(1'b0, 1'b1, 1'b1, 1'b0, w, l, '0);
endtask

task automatic idleCycle();
	accessCycle(1'b0, 1'b0, 1'b1, 1'b0, wordSelect, byteSelect, dataIn);
endtask

// Ends the test once every issued read is checked
task automatic finishTest();
	idleCycle();
	while (dueQ.size() > 0) begin
		idleCycle();
	end
	$display("Test %s: %0d checks, %0d errors", curTest, testChecks, testErrors);
	totalChecks += testChecks;
	totalErrors += testErrors;
	testsRun++;
endtask

function automatic wordAddrT pickFreshWord();
	wordAddrT w;
	w = wordAddrT'($urandom);
	while (wordFull[w]) begin
		w = wordAddrT'($urandom);
	end
	return w;
endfunction

function automatic wordAddrT pickKnownWord();
	return fullList[$urandom % fullList.size()];
endfunction

// Writes all four lanes so later reads never see unknown bits
task automatic fillWord(input wordAddrT w);
	for (int l = 0; l < `LANES; l++) begin
		writeByte(w, laneSelT'(l), byteT'($urandom));
	end
	wordFull[w] = 1'b1;
	fullList.push_back(w);
endtask

task automatic readWord(input wordAddrT w);
	for (int l = 0; l < `LANES; l++) begin
		readByte(w, laneSelT'(l));
	end
endtask

//##################################################
// Test sequences
//##################################################

task automatic testResetValue();
	startTest("resetValue");
	idleCycle();
	compareByte('0, dataOut, '0, '0);
	finishTest();
endtask

task automatic testFullWordFill();
	wordAddrT words[$];
	startTest("fullWordFill");
	for (int i = 0; i < FILL_WORDS; i++) begin
		words.push_back(pickFreshWord());
		fillWord(words[i]);
	end
	foreach (words[i]) readWord(words[i]);
	finishTest();
endtask

task automatic testLaneIsolation();
	wordAddrT w;
	startTest("laneIsolation");
	for (int i = 0; i < LANE_WORDS; i++) begin
		w = pickFreshWord();
		fillWord(w);
		writeByte(w, laneSelT'($urandom), byteT'($urandom));	// Overwrite one lane
		readWord(w);
	end
	finishTest();
endtask

task automatic testGatedAccess();
	wordAddrT w;
	laneSelT l;
	startTest("gatedAccess");
	for (int i = 0; i < GATE_WORDS; i++) begin
		w = pickKnownWord();
		l = laneSelT'($urandom);
		readByte(w, l);	// Known value on dataOut
		accessCycle(1'b1, 1'b0, 1'b1, 1'b1, w, l, ~expectedByte(w, l));
		accessCycle(1'b1, 1'b0, 1'b0, 1'b0, w, l ^ 2'd1, ~expectedByte(w, l ^ 2'd1));
		accessCycle(1'b0, 1'b1, 1'b1, 1'b1, w, l ^ 2'd2, '0);
		accessCycle(1'b0, 1'b1, 1'b0, 1'b0, w, l ^ 2'd3, '0);
		readWord(w);
	end
	finishTest();
endtask

task automatic testBackToBackReads();
	startTest("backToBackReads");
	for (int i = 0; i < BURST_READS; i++) begin
		readByte(pickKnownWord(), laneSelT'($urandom));
	end
	finishTest();
endtask

task automatic testReadAfterWrite();
	wordAddrT w;
	laneSelT l;
	startTest("readAfterWrite");
	for (int i = 0; i < RAW_PAIRS; i++) begin
		w = pickKnownWord();
		l = laneSelT'($urandom);
		writeByte(w, l, byteT'($urandom));
		readByte(w, l);
	end
	finishTest();
endtask

`endif

// File: dv/sramHeadTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "sramHead_settings.svh"

module sramHeadTb
	import sramHeadPkg::*;
();

	localparam int CLK_PERIOD = 100;
	localparam int RESET_CYCLES = 4;
	localparam int READ_LATENCY = 2;	// Sampling edge to dataOut edge

	// Test sizes
	localparam int FILL_WORDS = 8;
	localparam int LANE_WORDS = 6;
	localparam int GATE_WORDS = 4;
	localparam int BURST_READS = 40;
	localparam int RAW_PAIRS = 8;

	// Cycle budget per test, drain included
	localparam int TEST_CYCLES = 4 + (FILL_WORDS * 8 + 6) + (LANE_WORDS * 9 + 6) +
		(GATE_WORDS * 15 + 6) + (BURST_READS + 6) + (RAW_PAIRS * 2 + 6);
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + TEST_CYCLES + 50;

	logic clk;
	logic rstN;
	byteT dataIn;
	byteT dataOut;
	wordAddrT wordSelect;
	laneSelT byteSelect;
	logic writeEnable;
	logic readEnable;
	logic wordLineEnable;
	logic preCharge;

	// Shadow of the bank and its bookkeeping
	wordT shadow [`SRAM_WORDS];
	bit wordFull [`SRAM_WORDS];	// All four lanes written
	wordAddrT fullList[$];
	byteT predictedOut;	// dataOut after the latest issued read

	// Pending read checks, one entry per issued read
	byteT expQ[$];
	int dueQ[$];
	wordAddrT wordQ[$];
	laneSelT laneQ[$];

	int cycleCount;
	string curTest;
	int testChecks;
	int testErrors;
	int totalChecks;
	int totalErrors;
	int testsRun;

	sramHead uut (
		.clk(clk),
		.rstN(rstN),
		.dataIn(dataIn),
		.dataOut(dataOut),
		.wordSelect(wordSelect),
		.byteSelect(byteSelect),
		.writeEnable(writeEnable),
		.readEnable(readEnable),
		.wordLineEnable(wordLineEnable),
		.preCharge(preCharge)
	);

	//##################################################
	// Reference model
	//##################################################

	// Row driver on, bitlines released, exactly one strobe
	function automatic bit accessAllowed(input logic we, input logic re,
		input logic wle, input logic pc);
		return wle && !pc && (we != re);
	endfunction

	function automatic byteT expectedByte(input wordAddrT w, input laneSelT l);
		return shadow[w][l * `BYTE_W +: `BYTE_W];
	endfunction

	`include "sramHeadTasks.svh"

	//##################################################
	// Clock, cycle count and checker
	//##################################################

	always #(CLK_PERIOD / 2) clk = ~clk;

	always @(posedge clk) cycleCount <= cycleCount + 1;

	// dataOut is settled by the falling edge
	always @(negedge clk) begin
		while (dueQ.size() > 0 && dueQ[0] <= cycleCount) begin
			compareByte(expQ[0], dataOut, wordQ[0], laneQ[0]);
			void'(expQ.pop_front());
			void'(dueQ.pop_front());
			void'(wordQ.pop_front());
			void'(laneQ.pop_front());
		end
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Watchdog expired after %0d cycles, test %s did not finish",
			WATCHDOG_CYCLES, curTest);
		$display("=== FAIL ===");
		$finish;
	end

	//##################################################
	// Main sequence
	//##################################################

	initial begin
		clk = 1'b0;
		rstN = 1'b0;
		dataIn = '0;
		wordSelect = '0;
		byteSelect = '0;
		writeEnable = 1'b0;
		readEnable = 1'b0;
		wordLineEnable = 1'b0;
		preCharge = 1'b1;	// Bitlines precharged while in reset
		cycleCount = 0;
		predictedOut = '0;
		curTest = "reset";
		void'($urandom(32'h72c5_4414));

		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rstN = 1'b1;
		preCharge = 1'b0;

		testResetValue();
		testFullWordFill();
		testLaneIsolation();
		testGatedAccess();
		testBackToBackReads();
		testReadAfterWrite();

		$display("Summary: %0d tests, %0d checks, %0d errors",
			testsRun, totalChecks, totalErrors);
		if (totalErrors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: design/sramHead.sv
`timescale 1ns/1ps
`default_nettype none

module sramHead
	import sramHeadPkg::*;
(
	input logic clk,
	input logic rstN,
	input byteT dataIn,	// Write byte from the pins
	output byteT dataOut,	// Read byte to the pins
	input wordAddrT wordSelect,
	input laneSelT byteSelect,	// Lane for both read and write
	input logic writeEnable,
	input logic readEnable,
	input logic wordLineEnable,
	input logic preCharge
);

	sramArrayIf arrIf ();

	//##################################################
	// Access front end
	//##################################################

	wordLineDecoder uDecoder (
		.clk(clk),
		.rstN(rstN),
		.wordSelect(wordSelect),
		.readEnable(readEnable),
		.writeEnable(writeEnable),
		.wordLineEnable(wordLineEnable),
		.preCharge(preCharge),
		.arr(arrIf.decoder)
	);

	writeLaneSteering uSteering (
		.clk(clk),
		.rstN(rstN),
		.dataIn(dataIn),
		.byteSelect(byteSelect),
		.writeEnable(writeEnable),
		.arr(arrIf.steering)
	);

	//##################################################
	// Bank and read back
	//##################################################

	sramBitArray uBank (
		.clk(clk),
		.arr(arrIf.array)
	);

	// Read byte appears two edges after the pins are sampled
	readByteMux uOutMux (
		.clk(clk),
		.rstN(rstN),
		.byteSelect(byteSelect),
		.arr(arrIf.mux),
		.dataOut(dataOut)
	);

endmodule

`default_nettype wire

// File: design/readByteMux.sv
`timescale 1ns/1ps
`default_nettype none

`include "sramHead_settings.svh"

module readByteMux
	import sramHeadPkg::*;
(
	input logic clk,
	input logic rstN,
	input laneSelT byteSelect,
	sramArrayIf.mux arr,
	output byteT dataOut
);

	laneSelT laneIssued;	// Sampled with the access
	laneSelT laneSensed;	// Lines up with senseData
	logic readPending;

	//##################################################
	// Lane select pipeline
	//##################################################

	always_ff @(posedge clk) begin
		laneIssued <= byteSelect;
		laneSensed <= laneIssued;
	end

	// Set in the cycle after the array loaded senseData
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			readPending <= 1'b0;
		end else begin
			readPending <= (arr.op == opRead);
		end
	end

	//##################################################
	// Output byte register
	//##################################################

	// Holds the last byte between reads
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			dataOut <= '0;
		end else if (readPending) begin
			dataOut <= arr.senseData[laneSensed*`BYTE_W +: `BYTE_W];
		end
	end

	// An unwritten row read out would show up here
	a_outKnown: assert property (
		@(posedge clk) disable iff (!rstN)
		!$isunknown(dataOut)
	) else $error("dataOut unknown");

endmodule

`default_nettype wire

// File: design/sramBitArray.sv
`timescale 1ns/1ps
`default_nettype none

`include "sramHead_settings.svh"

module sramBitArray
	import sramHeadPkg::*;
(
	input logic clk,
	sramArrayIf.array arr
);

	wordT mem [`SRAM_WORDS];	// Bank storage
	wordAddrT rowAddr;

	//##################################################
	// Row encoder
	//##################################################

	// Wordline is one-hot, so OR of the raised indices is the row
	always_comb begin
		rowAddr = '0;
		for (int i = 0; i < `SRAM_WORDS; i++) begin
			if (arr.wordLine[i]) begin
				rowAddr = rowAddr | wordAddrT'(i);
			end
		end
	end

	//##################################################
	// Cell access
	//##################################################

	always_ff @(posedge clk) begin
		case (arr.op)
			opWrite: begin
				// Only enabled lanes are driven onto the bitlines
				for (int l = 0; l < `LANES; l++) begin
					if (arr.laneMask[l]) begin
						mem[rowAddr][l*`BYTE_W +: `BYTE_W] <=
							arr.writeData[l*`BYTE_W +: `BYTE_W];
					end
				end
			end
			opRead: begin
				arr.senseData <= mem[rowAddr];	// Sense amp latch
			end
			default: begin
				// Precharge or idle keeps the last sensed word
			end
		endcase
	end

	// Row select and opcode come from the decoder and must agree
	a_rowSelect: assert property (
		@(posedge clk)
		(arr.op == opIdle) ? (arr.wordLine == '0) : $onehot(arr.wordLine)
	) else $error("wordline does not match opcode %s", arr.op.name());

endmodule

`default_nettype wire

// File: design/writeLaneSteering.sv
`timescale 1ns/1ps
`default_nettype none

`include "sramHead_settings.svh"

module writeLaneSteering
	import sramHeadPkg::*;
(
	input logic clk,
	input logic rstN,
	input byteT dataIn,
	input laneSelT byteSelect,
	input logic writeEnable,
	sramArrayIf.steering arr
);

	wordT laneWord;
	laneMaskT laneBit;

	// Byte lands in its lane, other lanes stay zero
	always_comb begin
		laneWord = '0;
		laneWord[byteSelect*`BYTE_W +: `BYTE_W] = dataIn;
	end

	assign laneBit = laneMaskT'(1) << byteSelect;

	//##################################################
	// Input register toward the bank
	//##################################################

	always_ff @(posedge clk) begin
		arr.writeData <= laneWord;
	end

	// The array still checks op before it writes
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			arr.laneMask <= '0;
		end else if (writeEnable) begin
			arr.laneMask <= laneBit;
		end else begin
			arr.laneMask <= '0;	// No lane touched
		end
	end

endmodule

`default_nettype wire

// File: design/wordLineDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module wordLineDecoder
	import sramHeadPkg::*;
(
	input logic clk,
	input logic rstN,
	input wordAddrT wordSelect,
	input logic readEnable,
	input logic writeEnable,
	input logic wordLineEnable,
	input logic preCharge,
	sramArrayIf.decoder arr
);

	logic accessOk;
	accessOpT nextOp;
	wordLineT nextWordLine;

	//##################################################
	// Access qualification
	//##################################################

	// Bitlines must be released and the row driver on
	assign accessOk = wordLineEnable && !preCharge && (readEnable != writeEnable);

	always_comb begin
		if (!accessOk) begin
			nextOp = opIdle;
		end else if (writeEnable) begin
			nextOp = opWrite;
		end else begin
			nextOp = opRead;
		end
	end

	// No row is raised for an idle cycle
	always_comb begin
		nextWordLine = '0;
		if (accessOk) begin
			nextWordLine = wordLineT'(1) << wordSelect;
		end
	end

	//##################################################
	// Registered row select
	//##################################################

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			arr.wordLine <= '0;
			arr.op <= opIdle;
		end else begin
			arr.wordLine <= nextWordLine;
			arr.op <= nextOp;
		end
	end

	// Both strobes at once is a pin protocol error
	a_singleStrobe: assert property (
		@(posedge clk) disable iff (!rstN)
		!(readEnable && writeEnable)
	) else $error("readEnable and writeEnable both high");

endmodule

`default_nettype wire

// File: design/sramArrayIf.sv
`timescale 1ns/1ps
`default_nettype none

interface sramArrayIf
	import sramHeadPkg::*;
();

	// Row select and access type from the decoder
	wordLineT wordLine;
	accessOpT op;

	// Lane-steered write word and its enables
	wordT writeData;
	laneMaskT laneMask;

	wordT senseData;	// Word read from the bank

	modport decoder (
		output wordLine,
		output op
	);

	modport steering (
		output writeData,
		output laneMask
	);

	modport array (
		input wordLine,
		input op,
		input writeData,
		input laneMask,
		output senseData
	);

	// op tells the mux that senseData was just loaded
	modport mux (
		input op,
		input senseData
	);

endinterface

`default_nettype wire

// File: design/sramHeadPkg.sv
`default_nettype none

`include "sramHead_settings.svh"

package sramHeadPkg;

	// Address and data shapes of the bank
	typedef logic [`WORD_SEL_W-1:0] wordAddrT;
	typedef logic [`WORD_W-1:0] wordT;
	typedef logic [`BYTE_W-1:0] byteT;

	typedef logic [`LANE_SEL_W-1:0] laneSelT;	// Byte lane index
	typedef logic [`LANES-1:0] laneMaskT;	// One write enable per lane

	typedef logic [`SRAM_WORDS-1:0] wordLineT;	// One-hot row select

	// Access seen by the array in a given cycle
	typedef enum logic [1:0] {
		opIdle = 2'd0,
		opRead = 2'd1,
		opWrite = 2'd2
	} accessOpT;

endpackage

`default_nettype wire

// File: design/sramHead_settings.svh
`ifndef SRAMHEAD_SETTINGS_SVH
`define SRAMHEAD_SETTINGS_SVH

// Bank geometry
`define SRAM_WORDS 1024
`define WORD_SEL_W 10

// One word is split into byte lanes
`define WORD_W 32
`define BYTE_W 8
`define LANES 4
`define LANE_SEL_W 2

`endif
